/* Makefile */
# Verilator build and run of the pnp subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_pnp_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
	  echo "simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src.f */
verilog/pnp_pkg.sv
verilog/sysbus_if.sv
verilog/sysbus_arbiter.sv
verilog/pnp_regs.sv
verilog/sram_slave.sv
verilog/pnp_top.sv
test/tb_pnp_top.sv

/* test/tb_pnp_top.sv */
// tb_pnp_top, table-driven testbench for the host and debug ports of the pnp subsystem
`timescale 1ns/1ps
`default_nettype none

module tb_pnp_top
  import pnp_pkg::*;
();

  localparam int          ack_timeout = 20;
  localparam int          ack_latency = 4;  // falling edges from drive edge to ack
  localparam logic [31:0] exp_hw_id   = 32'h2022_1123;
  localparam logic [63:0] cap_word    = {32'd0, 4'd1, 3'd0, 1'b1, 8'd0, 8'(n_slots), 8'd127};

  typedef struct packed {
    logic              dbg;
    logic              pair;       // issued together with the next row
    logic              wr;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] strb;
    logic [data_w-1:0] exp_rdata;  // reads only
    logic              irq;
  } row_t;

  logic              sys_clk;
  logic              nrst;
  logic              i_h_req;
  logic              i_h_write;
  logic [addr_w-1:0] i_h_addr;
  logic [data_w-1:0] i_h_wdata;
  logic [strb_w-1:0] i_h_wstrb;
  logic              o_h_ack;
  logic [data_w-1:0] o_h_rdata;
  logic              i_d_req;
  logic              i_d_write;
  logic [addr_w-1:0] i_d_addr;
  logic [data_w-1:0] i_d_wdata;
  logic [strb_w-1:0] i_d_wstrb;
  logic              o_d_ack;
  logic [data_w-1:0] o_d_rdata;
  logic              o_irq;

  row_t        rows [$];
  logic [31:0] lfsr = 32'h3f54_4972;
  logic        last_dbg = 1'b1;  // host is favoured after reset
  logic        timed_out = 1'b0;
  int          n_tests = 0;
  int          n_err = 0;

  pnp_top dut (.*);

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  function automatic logic [63:0] rand_word();
    logic [63:0] v;
    v = '0;
    for (int b = 0; b < 64; b++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32,22,2,1
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [63:0] merge_bytes(logic [63:0] old_w, logic [63:0] new_w,
                                              logic [7:0] strb);
    logic [63:0] m;
    m = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) m[8*b +: 8] = new_w[8*b +: 8];
    end
    return m;
  endfunction

  function automatic void add_row(logic dbg, logic pair, logic wr, logic [addr_w-1:0] addr,
                                  logic [63:0] wdata, logic [7:0] strb, logic [63:0] exp_rdata,
                                  logic irq);
    rows.push_back(row_t'{dbg, pair, wr, addr, wdata, strb, exp_rdata, irq});
  endfunction

  function automatic logic get_ack(logic dbg);
    return dbg ? o_d_ack : o_h_ack;
  endfunction

  function automatic logic [63:0] get_rdata(logic dbg);
    return dbg ? o_d_rdata : o_h_rdata;
  endfunction

  task automatic fail_value(int idx, string sig, logic [63:0] got, logic [63:0] exp_v);
    $display("[FAIL] row %0d %s got %h expected %h", idx, sig, got, exp_v);
    n_err++;
  endtask

  task automatic note_err(string msg);
    $display("%s", msg);
    n_err++;
  endtask

  task automatic drive_port(row_t r);
    if (r.dbg) begin
      i_d_req   <= 1'b1;
      i_d_write <= r.wr;
      i_d_addr  <= r.addr;
      i_d_wdata <= r.wdata;
      i_d_wstrb <= r.strb;
    end else begin
      i_h_req   <= 1'b1;
      i_h_write <= r.wr;
      i_h_addr  <= r.addr;
      i_h_wdata <= r.wdata;
      i_h_wstrb <= r.strb;
    end
  endtask

  task automatic check_rdata(int idx, row_t r);
    if (!r.wr && get_rdata(r.dbg) !== r.exp_rdata) begin
      fail_value(idx, r.dbg ? "o_d_rdata" : "o_h_rdata", get_rdata(r.dbg), r.exp_rdata);
    end
  endtask

  task automatic build_table();
    logic [63:0] v [4];
    logic [63:0] p;
    int          sidx [4] = '{0, 1, 32, 63};
    add_row(0, 1, 0, 13'h000, '0, '0, {32'd0, exp_hw_id}, 0);  // both ports at once
    add_row(1, 0, 0, 13'h008, '0, '0, cap_word, 0);
    for (int s = 0; s < n_slots; s++) begin
      add_row(s[0], 0, 0, 13'(64 + 32*s), '0, '0,
              {vendor_id, dev_id[s], 22'd0, DESCR_SLAVE, 8'd32}, 0);
      add_row(s[0], 0, 0, 13'(72 + 32*s), '0, '0, '0, 0);
      add_row(s[0], 0, 0, 13'(80 + 32*s), '0, '0, dev_start[s], 0);
      add_row(s[0], 0, 0, 13'(88 + 32*s), '0, '0, dev_end[s], 0);
    end
    add_row(1, 0, 0, 13'h0a0, '0, '0, '0, 0);  // index 20
    for (int k = 2; k <= 7; k++) begin
      add_row(k[0], 0, 1, 13'(8*k), {16'hf00d, 8'(k), 40'h960f3ca55a},
              (k == 7) ? 8'h01 : 8'hff, '0, 0);
    end
    for (int k = 2; k <= 7; k++) begin
      add_row(!k[0], 0, 0, 13'(8*k), '0, '0, {16'hf00d, 8'(k), 40'h960f3ca55a}, 0);
    end
    add_row(0, 0, 1, 13'h000, 64'hcafe_f00d_ffff_ffff, 8'hf0, '0, 0);
    add_row(1, 0, 0, 13'h000, '0, '0, {32'hcafe_f00d, exp_hw_id}, 0);
    add_row(1, 0, 1, 13'h000, 64'h0123_4567_dead_beef, 8'h0f, '0, 1);  // read-only hw id
    add_row(0, 0, 0, 13'h000, '0, '0, {32'hcafe_f00d, exp_hw_id}, 0);
    add_row(0, 0, 1, 13'h008, '1, 8'hff, '0, 0);
    add_row(1, 0, 0, 13'h008, '0, '0, cap_word, 0);
    for (int k = 0; k < 4; k++) begin
      v[k] = rand_word();
      add_row(k[0], 0, 1, 13'h1000 + 13'(8*sidx[k]), v[k], 8'hff, '0, 0);
    end
    for (int k = 0; k < 4; k++) begin
      add_row(!k[0], 0, 0, 13'h1000 + 13'(8*sidx[k]), '0, '0, v[k], 0);
    end
    p = rand_word();
    add_row(1, 0, 1, 13'h1008, p, 8'h3c, '0, 0);
    add_row(0, 0, 0, 13'h1008, '0, '0, merge_bytes(v[1], p, 8'h3c), 0);
    add_row(0, 1, 0, 13'h1000, '0, '0, v[0], 0);  // host won last, debug goes first
    add_row(1, 0, 0, 13'h010, '0, '0, {16'hf00d, 8'd2, 40'h960f3ca55a}, 0);
  endtask

  task automatic run_single(int idx);
    row_t r;
    int   cycles;
    int   irq_cnt;
    logic irq_prev;
    logic acked;
    int   err0;
    r = rows[idx];
    err0 = n_err;
    cycles = 0;
    irq_cnt = 0;
    irq_prev = 1'b0;
    acked = 1'b0;
    @(posedge sys_clk);
    drive_port(r);
    while (!acked) begin
      @(negedge sys_clk);
      cycles++;
      acked = get_ack(r.dbg);
      if (get_ack(!r.dbg)) note_err($sformatf("row %0d: the idle port was acknowledged", idx));
      if (!acked) begin
        irq_prev = o_irq;  // the cycle before ack carries the irq
        irq_cnt += int'(o_irq);
        if (cycles >= ack_timeout) begin
          $display("row %0d: no ack within %0d cycles", idx, ack_timeout);
          timed_out = 1'b1;
          return;
        end
      end
    end
    irq_cnt += int'(o_irq);
    check_rdata(idx, r);
    if (cycles != ack_latency) fail_value(idx, "ack latency", 64'(cycles), 64'(ack_latency));
    @(posedge sys_clk);
    if (r.dbg) i_d_req <= 1'b0;
    else i_h_req <= 1'b0;
    @(negedge sys_clk);
    irq_cnt += int'(o_irq);
    if (get_ack(r.dbg)) note_err($sformatf("row %0d: ack lasted more than one cycle", idx));
    if (irq_cnt != int'(r.irq) || irq_prev != r.irq) begin
      fail_value(idx, "o_irq pulses", 64'(irq_cnt), 64'(r.irq));
    end
    last_dbg = r.dbg;
    n_tests++;
    $display("row %0d %s %s 0x%h: %0d errors", idx, r.dbg ? "debug" : "host",
             r.wr ? "write" : "read", r.addr, n_err - err0);
  endtask

  task automatic run_pair(int idx);
    logic h_done;
    logic d_done;
    logic first_dbg;
    logic exp_first_dbg;
    int   cycles;
    int   err0;
    err0 = n_err;
    h_done = 1'b0;
    d_done = 1'b0;
    first_dbg = 1'b0;
    cycles = 0;
    exp_first_dbg = !last_dbg;  // the port that did not win last time
    @(posedge sys_clk);
    drive_port(rows[idx]);
    drive_port(rows[idx+1]);
    while (!(h_done && d_done)) begin
      @(negedge sys_clk);
      cycles++;
      if (o_h_ack) begin
        if (h_done) note_err($sformatf("row %0d: host port acknowledged twice", idx));
        h_done = 1'b1;
        check_rdata(idx, rows[idx]);
      end
      if (o_d_ack) begin
        if (d_done) note_err($sformatf("row %0d: debug port acknowledged twice", idx + 1));
        if (!h_done) first_dbg = 1'b1;
        d_done = 1'b1;
        check_rdata(idx + 1, rows[idx+1]);
      end
      if (!(h_done && d_done) && cycles >= ack_timeout) begin
        $display("row %0d: both ports not acknowledged within %0d cycles", idx, ack_timeout);
        timed_out = 1'b1;
        return;
      end
      @(posedge sys_clk);
      if (h_done) i_h_req <= 1'b0;
      if (d_done) i_d_req <= 1'b0;
    end
    @(negedge sys_clk);
    if (o_h_ack || o_d_ack) note_err($sformatf("row %0d: extra ack after the pair", idx));
    if (first_dbg != exp_first_dbg) fail_value(idx, "first ack dbg", 64'(first_dbg),
                                               64'(exp_first_dbg));
    last_dbg = !exp_first_dbg;
    n_tests++;
    $display("rows %0d-%0d simultaneous pair: %0d errors", idx, idx + 1, n_err - err0);
  endtask

  initial begin
    int i;
    nrst <= 1'b0;
    i_h_req <= 1'b0;
    i_h_write <= 1'b0;
    i_h_addr <= '0;
    i_h_wdata <= '0;
    i_h_wstrb <= '0;
    i_d_req <= 1'b0;
    i_d_write <= 1'b0;
    i_d_addr <= '0;
    i_d_wdata <= '0;
    i_d_wstrb <= '0;
    build_table();
    for (int c = 0; c < 4; c++) begin
      @(posedge sys_clk);
      if (c == 2) nrst <= 1'b1;  // third rising edge still sees reset
      @(negedge sys_clk);
      if (o_h_ack || o_d_ack || o_irq) begin
        fail_value(-1, "reset acks and irq", 64'({o_h_ack, o_d_ack, o_irq}), 64'h0);
      end
    end
    i = 0;
    while (i < rows.size() && !timed_out) begin
      if (rows[i].pair) begin
        run_pair(i);
        i += 2;
      end else begin
        run_single(i);
        i += 1;
      end
    end
    $display("%0d tests run, %0d errors, timeout %0d", n_tests, n_err, timed_out);
    if (n_err == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/pnp_pkg.sv */
// pnp package with system bus widths, address map and the fixed plug-and-play device table
`default_nettype none

package pnp_pkg;

  localparam int addr_w        = 13;  // byte address
  localparam int data_w        = 64;
  localparam int strb_w        = 8;
  localparam int sram_base_bit = 12;  // set selects the sram
  localparam int n_slots       = 2;   // pnp_regs and sram

  localparam logic [7:0] descr_size = 8'd32;  // 4 words of 8 bytes

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_BUS,
    ARB_RESP
  } arb_state_e;

  typedef enum logic [1:0] {
    DESCR_MASTER = 2'd1,
    DESCR_SLAVE  = 2'd2
  } descr_type_e;

  localparam logic [15:0] vendor_id   = 16'h00f1;
  localparam logic [15:0] dev_id_pnp  = 16'h0071;
  localparam logic [15:0] dev_id_sram = 16'h0073;

  // slot 0 is the register block, slot 1 the scratch memory
  localparam logic [15:0] dev_id [n_slots] = '{
    dev_id_pnp,
    dev_id_sram
  };

  localparam descr_type_e dev_type [n_slots] = '{
    DESCR_SLAVE,
    DESCR_SLAVE
  };

  localparam logic [63:0] dev_start [n_slots] = '{
    64'h0000_0000_0000_0000,
    64'h0000_0000_0000_1000
  };

  localparam logic [63:0] dev_end [n_slots] = '{
    64'h0000_0000_0000_0fff,
    64'h0000_0000_0000_1fff
  };

endpackage

`default_nettype wire

/* verilog/pnp_regs.sv */
// pnp_regs, hardware configuration storage with ids, firmware words and device descriptors
`timescale 1ns/1ps
`default_nettype none

module pnp_regs
  import pnp_pkg::*;
#(
  parameter logic [31:0] hw_id       = 32'h2022_1123,
  parameter logic [3:0]  cpu_max     = 4'd1,
  parameter logic        l2cache_ena = 1'b1,
  parameter logic [7:0]  irq_max     = 8'd127
) (
  input  logic     sys_clk,
  input  logic     nrst,
  sysbus_if.slave  bus,
  output logic     o_irq  // self-test, write into read-only field
);

  localparam int n_descr = 4 * n_slots;

  logic [8:0]        idx;
  logic              wr_en;
  logic              ro_hit;
  logic [31:0]       fw_id;
  logic [data_w-1:0] fw_word [2:7];
  logic [data_w-1:0] descr [0:n_descr-1];
  logic [data_w-1:0] cap_word;
  logic [data_w-1:0] rd_mux;
  logic              irq_q;

  assign idx    = bus.addr[11:3];  // word index
  assign wr_en  = bus.req & bus.write;
  assign ro_hit = wr_en & (idx == 9'd0) & (|bus.wstrb[3:0]);

  assign cap_word = {
    32'd0,
    cpu_max,
    3'd0,
    l2cache_ena,
    8'd0,
    8'(n_slots),
    irq_max
  };

  always_comb begin
    for (int k = 0; k < n_slots; k++) begin
      descr[4*k]   = {vendor_id, dev_id[k], 22'd0, dev_type[k], descr_size};
      descr[4*k+1] = '0;  // reserved
      descr[4*k+2] = dev_start[k];
      descr[4*k+3] = dev_end[k];
    end
  end

  always_comb begin
    rd_mux = '0;
    if (idx == 9'd0) begin
      rd_mux = {fw_id, hw_id};
    end else if (idx == 9'd1) begin
      rd_mux = cap_word;
    end else if (idx >= 9'd2 && idx <= 9'd7) begin
      rd_mux = fw_word[idx[2:0]];
    end else if (idx >= 9'd8 && int'(idx) < 8 + n_descr) begin
      rd_mux = descr[int'(idx) - 8];
    end
  end

  always_ff @(posedge sys_clk or negedge nrst) begin
    if (!nrst) begin
      fw_id     <= '0;
      irq_q     <= 1'b0;
      bus.rdata <= '0;
      for (int i = 2; i <= 7; i++) begin
        fw_word[i] <= '0;
      end
    end else begin
      irq_q <= ro_hit;
      if (bus.req) begin
        bus.rdata <= rd_mux;  // old value on a write
      end
      if (wr_en) begin
        if (idx == 9'd0 && (|bus.wstrb[7:4])) begin
          fw_id <= bus.wdata[63:32];
        end
        if (idx >= 9'd2 && idx <= 9'd7) begin
          fw_word[idx[2:0]] <= bus.wdata;  // full word, strobes ignored
        end
      end
    end
  end

  assign o_irq = irq_q;

  // accesses are spaced by the arbiter, so the pulse cannot stretch
  a_irq_pulse: assert property (@(posedge sys_clk) disable iff (!nrst)
    o_irq |=> !o_irq);

endmodule

`default_nettype wire

/* verilog/pnp_top.sv */
// pnp_top, host and debug ports sharing the system bus to the pnp registers and sram
`timescale 1ns/1ps
`default_nettype none

module pnp_top
  import pnp_pkg::*;
#(
  parameter logic [31:0] hw_id       = 32'h2022_1123,
  parameter logic [3:0]  cpu_max     = 4'd1,
  parameter logic        l2cache_ena = 1'b1,
  parameter logic [7:0]  irq_max     = 8'd127,
  parameter int          sram_words  = 64
) (
  input  logic              sys_clk,
  input  logic              nrst,
  input  logic              i_h_req,
  input  logic              i_h_write,
  input  logic [addr_w-1:0] i_h_addr,
  input  logic [data_w-1:0] i_h_wdata,
  input  logic [strb_w-1:0] i_h_wstrb,
  output logic              o_h_ack,
  output logic [data_w-1:0] o_h_rdata,
  input  logic              i_d_req,
  input  logic              i_d_write,
  input  logic [addr_w-1:0] i_d_addr,
  input  logic [data_w-1:0] i_d_wdata,
  input  logic [strb_w-1:0] i_d_wstrb,
  output logic              o_d_ack,
  output logic [data_w-1:0] o_d_rdata,
  output logic              o_irq
);

  sysbus_if pnp_bus ();
  sysbus_if sram_bus ();

  sysbus_arbiter u_arbiter (
    .sys_clk   (sys_clk),
    .nrst      (nrst),
    .i_h_req   (i_h_req),
    .i_h_write (i_h_write),
    .i_h_addr  (i_h_addr),
    .i_h_wdata (i_h_wdata),
    .i_h_wstrb (i_h_wstrb),
    .o_h_ack   (o_h_ack),
    .o_h_rdata (o_h_rdata),
    .i_d_req   (i_d_req),
    .i_d_write (i_d_write),
    .i_d_addr  (i_d_addr),
    .i_d_wdata (i_d_wdata),
    .i_d_wstrb (i_d_wstrb),
    .o_d_ack   (o_d_ack),
    .o_d_rdata (o_d_rdata),
    .pnp_bus   (pnp_bus),
    .sram_bus  (sram_bus)
  );

  pnp_regs #(
    .hw_id       (hw_id),
    .cpu_max     (cpu_max),
    .l2cache_ena (l2cache_ena),
    .irq_max     (irq_max)
  ) u_pnp_regs (
    .sys_clk (sys_clk),
    .nrst    (nrst),
    .bus     (pnp_bus),
    .o_irq   (o_irq)
  );

  sram_slave #(
    .sram_words (sram_words)
  ) u_sram (
    .sys_clk (sys_clk),
    .nrst    (nrst),
    .bus     (sram_bus)
  );

endmodule

`default_nettype wire

/* verilog/sram_slave.sv */
// sram_slave, scratch word memory with byte strobes and registered read data
`timescale 1ns/1ps
`default_nettype none

module sram_slave
  import pnp_pkg::*;
#(
  parameter int sram_words = 64  // power of two
) (
  input  logic    sys_clk,
  input  logic    nrst,
  sysbus_if.slave bus
);

  localparam int idx_w = $clog2(sram_words);

  logic [data_w-1:0] mem [0:sram_words-1];
  logic [idx_w-1:0]  idx;

  assign idx = bus.addr[3 +: idx_w];  // wraps at sram_words

  always_ff @(posedge sys_clk) begin
    if (bus.req && bus.write) begin
      for (int b = 0; b < strb_w; b++) begin
        if (bus.wstrb[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge sys_clk or negedge nrst) begin
    if (!nrst) begin
      bus.rdata <= '0;
    end else if (bus.req) begin
      bus.rdata <= mem[idx];  // pre-write contents
    end
  end

  a_wr_strb: assert property (@(posedge sys_clk) disable iff (!nrst)
    bus.req && bus.write |-> |bus.wstrb);

endmodule

`default_nettype wire

/* verilog/sysbus_arbiter.sv */
// sysbus arbiter, round-robin between host and debug ports with slave decode
`timescale 1ns/1ps
`default_nettype none

module sysbus_arbiter
  import pnp_pkg::*;
(
  input  logic              sys_clk,
  input  logic              nrst,
  input  logic              i_h_req,
  input  logic              i_h_write,
  input  logic [addr_w-1:0] i_h_addr,
  input  logic [data_w-1:0] i_h_wdata,
  input  logic [strb_w-1:0] i_h_wstrb,
  output logic              o_h_ack,
  output logic [data_w-1:0] o_h_rdata,
  input  logic              i_d_req,
  input  logic              i_d_write,
  input  logic [addr_w-1:0] i_d_addr,
  input  logic [data_w-1:0] i_d_wdata,
  input  logic [strb_w-1:0] i_d_wstrb,
  output logic              o_d_ack,
  output logic [data_w-1:0] o_d_rdata,
  sysbus_if.master          pnp_bus,
  sysbus_if.master          sram_bus
);

  arb_state_e        state;
  logic              prefer_dbg;  // round-robin pointer
  logic              h_pend;
  logic              d_pend;
  logic              grant_dbg;
  logic              sel_dbg;     // winner of the current access
  logic              sel_sram;
  logic              cap_write;
  logic [addr_w-1:0] cap_addr;
  logic [data_w-1:0] cap_wdata;
  logic [strb_w-1:0] cap_wstrb;
  logic [data_w-1:0] resp_rdata;

  // a port still holds its old req in the ack cycle
  assign h_pend    = i_h_req & ~o_h_ack;
  assign d_pend    = i_d_req & ~o_d_ack;
  assign grant_dbg = d_pend & (~h_pend | prefer_dbg);

  always_ff @(posedge sys_clk or negedge nrst) begin
    if (!nrst) begin
      state      <= ARB_IDLE;
      prefer_dbg <= 1'b0;  // host first
      sel_dbg    <= 1'b0;
      sel_sram   <= 1'b0;
      o_h_ack    <= 1'b0;
      o_d_ack    <= 1'b0;
    end else begin
      o_h_ack <= 1'b0;
      o_d_ack <= 1'b0;
      case (state)
        ARB_IDLE: begin
          if (h_pend | d_pend) begin
            state      <= ARB_BUS;
            sel_dbg    <= grant_dbg;
            prefer_dbg <= ~grant_dbg;
            sel_sram   <= grant_dbg ? i_d_addr[sram_base_bit] : i_h_addr[sram_base_bit];
          end
        end
        ARB_BUS:  state <= ARB_RESP;
        ARB_RESP: begin
          state   <= ARB_IDLE;
          o_h_ack <= ~sel_dbg;
          o_d_ack <= sel_dbg;
        end
        default:  state <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == ARB_IDLE) begin
      cap_write <= grant_dbg ? i_d_write : i_h_write;
      cap_addr  <= grant_dbg ? i_d_addr  : i_h_addr;
      cap_wdata <= grant_dbg ? i_d_wdata : i_h_wdata;
      cap_wstrb <= grant_dbg ? i_d_wstrb : i_h_wstrb;
    end
    if (state == ARB_RESP) begin
      if (sel_dbg) begin
        o_d_rdata <= resp_rdata;
      end else begin
        o_h_rdata <= resp_rdata;
      end
    end
  end

  assign pnp_bus.req    = (state == ARB_BUS) & ~sel_sram;
  assign pnp_bus.write  = cap_write;
  assign pnp_bus.addr   = cap_addr;
  assign pnp_bus.wdata  = cap_wdata;
  assign pnp_bus.wstrb  = cap_wstrb;
  assign sram_bus.req   = (state == ARB_BUS) & sel_sram;
  assign sram_bus.write = cap_write;
  assign sram_bus.addr  = cap_addr;
  assign sram_bus.wdata = cap_wdata;
  assign sram_bus.wstrb = cap_wstrb;

  assign resp_rdata = sel_sram ? sram_bus.rdata : pnp_bus.rdata;

  a_one_ack: assert property (@(posedge sys_clk) disable iff (!nrst)
    !(o_h_ack && o_d_ack));
  a_one_bus: assert property (@(posedge sys_clk) disable iff (!nrst)
    !(pnp_bus.req && sram_bus.req));
  // a bus pulse comes straight out of idle, once per grant
  a_req_bus: assert property (@(posedge sys_clk) disable iff (!nrst)
    (pnp_bus.req || sram_bus.req) |-> state == ARB_BUS && $past(state) == ARB_IDLE);

endmodule

`default_nettype wire

/* verilog/sysbus_if.sv */
// sysbus interface carrying one single-word access from the arbiter to a slave
`timescale 1ns/1ps
`default_nettype none

interface sysbus_if
  import pnp_pkg::*;
();

  logic              req;    // one-cycle pulse
  logic              write;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic [data_w-1:0] rdata;  // one cycle after req

  modport master (
    output req,
    output write,
    output addr,
    output wdata,
    output wstrb,
    input  rdata
  );

  modport slave (
    input  req,
    input  write,
    input  addr,
    input  wdata,
    input  wstrb,
    output rdata
  );

endinterface

`default_nettype wire
